// ==== verilog/mpmc_pkg.sv ====
package mpmc_pkg;

	// ========================================================================
	// Widths and the types that carry them
	// ========================================================================
	localparam int BUS_AW = 32;
	localparam int WINDOW_MSB = 31;
	localparam int WINDOW_LSB = 29;
	localparam int MEM_AW = WINDOW_LSB;
	localparam int STRIP_W = 128;
	localparam int STRIP_BYTES = STRIP_W / 8;
	localparam int CH0_W = 128;
	localparam int CH1_W = 32;

	typedef logic [BUS_AW-1:0] bus_addr_t;
	typedef logic [MEM_AW-1:0] mem_addr_t;
	typedef logic [STRIP_W-1:0] strip_t;
	typedef logic [STRIP_BYTES-1:0] strip_mask_t;
	typedef logic [CH0_W-1:0] ch0_data_t;
	typedef logic [CH0_W/8-1:0] ch0_sel_t;
	typedef logic [CH1_W-1:0] ch1_data_t;
	typedef logic [CH1_W/8-1:0] ch1_sel_t;
	typedef logic [0:0] ch_id_t;
	typedef logic [2:0] mig_cmd_t;

	// MIG user port commands
	localparam mig_cmd_t CMD_READ = 3'b001;
	localparam mig_cmd_t CMD_WRITE = 3'b000;

	// Strip (line) address starts here, 32-bit lanes start at LANE_LSB
	localparam int STRIP_LSB = 4;
	localparam int LANE_LSB = 2;
	localparam int ELEVATE_PERIOD = 64;
	// Never matches, the window keeps bits 31:29 at zero
	localparam bus_addr_t INVALID_TAG = '1;

	typedef enum logic [2:0] {
		IDLE, PRESET1, PRESET2, SEND_DATA, SET_CMD_WR, SET_CMD_RD, WAIT_RD, WAIT_NACK
	} seq_state_e;

endpackage

// ==== verilog/mpmc_channel_decode.sv ====
`timescale 1ns/1ns

module mpmc_channel_decode import mpmc_pkg::*; (
	input  logic        mem_ui_clk,
	input  logic        mem_ui_rst,
	input  logic        cyc0_i,
	input  logic        stb0_i,
	input  logic        we0_i,
	input  ch0_sel_t    sel0_i,
	input  bus_addr_t   adr0_i,
	input  ch0_data_t   dat0_i,
	input  logic        cyc1_i,
	input  logic        stb1_i,
	input  logic        we1_i,
	input  ch1_sel_t    sel1_i,
	input  bus_addr_t   adr1_i,
	input  ch1_data_t   dat1_i,
	input  logic        hit0_i,
	input  logic        hit1_i,
	input  logic        seq_idle_i,
	output logic        q_cs0_o,
	output logic        q_we0_o,
	output bus_addr_t   q_adr0_o,
	output logic        q_cs1_o,
	output logic        q_we1_o,
	output bus_addr_t   q_adr1_o,
	output logic        grant_o,
	output ch_id_t      grant_ch_o,
	output logic        grant_we_o,
	output mem_addr_t   grant_addr_o,
	output strip_t      grant_data_o,
	output strip_mask_t grant_mask_o
);

	ch0_sel_t q_sel0;
	ch0_data_t q_dat0;
	ch1_sel_t q_sel1;
	ch1_data_t q_dat1;
	logic elig0;
	logic elig1;
	logic pick1;
	logic grant_next;
	logic elevate;
	logic [$clog2(ELEVATE_PERIOD)-1:0] elev_cnt;
	strip_t strip_data;
	strip_mask_t strip_mask;

	function automatic mem_addr_t strip_addr(input bus_addr_t adr);
		return {adr[WINDOW_LSB-1:STRIP_LSB], {STRIP_LSB{1'b0}}};
	endfunction

	// ========================================================================
	// Request registers with the address window check
	// ========================================================================
	always_ff @(posedge mem_ui_clk) begin
		if (mem_ui_rst) begin
			q_cs0_o <= 1'b0;
			q_cs1_o <= 1'b0;
		end else begin
			q_cs0_o <= cyc0_i & stb0_i & (adr0_i[WINDOW_MSB:WINDOW_LSB] == '0);
			q_cs1_o <= cyc1_i & stb1_i & (adr1_i[WINDOW_MSB:WINDOW_LSB] == '0);
		end
	end

	always_ff @(posedge mem_ui_clk) begin
		q_we0_o <= we0_i;
		q_adr0_o <= adr0_i;
		q_sel0 <= sel0_i;
		q_dat0 <= dat0_i;
		q_we1_o <= we1_i;
		q_adr1_o <= adr1_i;
		q_sel1 <= sel1_i;
		q_dat1 <= dat1_i;
	end

	// A read that hits its cache never needs the memory
	assign elig0 = q_cs0_o & (q_we0_o | ~hit0_i);
	assign elig1 = q_cs1_o & (q_we1_o | ~hit1_i);

	// Channel 0 first, reversed while elevated
	assign pick1 = elevate ? elig1 : (elig1 & ~elig0);
	assign grant_next = seq_idle_i & ~grant_o & (elig0 | elig1);

	// Strip data and byte mask of the winning channel
	always_comb begin
		if (pick1) begin
			strip_data = {(STRIP_W / CH1_W){q_dat1}};
			strip_mask = ~({{(STRIP_BYTES - CH1_W / 8){1'b0}}, q_sel1}
				<< {q_adr1_o[STRIP_LSB-1:LANE_LSB], 2'b00});
		end else begin
			strip_data = q_dat0;
			strip_mask = ~q_sel0;
		end
		// Bytes that are not written go out as FF
		for (int b = 0; b < STRIP_BYTES; b++) begin
			if (strip_mask[b])
				strip_data[b*8 +: 8] = 8'hFF;
		end
	end

	// ========================================================================
	// Grant pulse and the elevate counter
	// ========================================================================
	always_ff @(posedge mem_ui_clk) begin
		if (mem_ui_rst) begin
			grant_o <= 1'b0;
			elevate <= 1'b0;
			elev_cnt <= '0;
		end else begin
			grant_o <= grant_next;
			if (grant_next) begin
				elev_cnt <= elev_cnt + 1'b1;
				elevate <= (elev_cnt == $bits(elev_cnt)'(ELEVATE_PERIOD - 2));
			end
		end
	end

	always_ff @(posedge mem_ui_clk) begin
		if (grant_next) begin
			grant_ch_o <= ch_id_t'(pick1);
			grant_we_o <= pick1 ? q_we1_o : q_we0_o;
			grant_addr_o <= pick1 ? strip_addr(q_adr1_o) : strip_addr(q_adr0_o);
			grant_data_o <= strip_data;
			grant_mask_o <= strip_mask;
		end
	end

endmodule

// ==== verilog/mpmc_mig_sequencer.sv ====
`timescale 1ns/1ns

module mpmc_mig_sequencer import mpmc_pkg::*; (
	input  logic        mem_ui_clk,
	input  logic        mem_ui_rst,
	input  logic        grant_i,
	input  ch_id_t      grant_ch_i,
	input  logic        grant_we_i,
	input  mem_addr_t   grant_addr_i,
	input  strip_t      grant_data_i,
	input  strip_mask_t grant_mask_i,
	input  logic        ack0_i,
	input  logic        ack1_i,
	input  strip_t      mem_rd_data_i,
	input  logic        mem_rd_data_valid_i,
	input  logic        mem_rd_data_end_i,
	input  logic        mem_rdy_i,
	input  logic        mem_wdf_rdy_i,
	output logic        seq_idle_o,
	output logic        fill_o,
	output ch_id_t      fill_ch_o,
	output strip_t      fill_data_o,
	output logic        wr_done_o,
	output ch_id_t      done_ch_o,
	output mem_addr_t   mem_addr_o,
	output mig_cmd_t    mem_cmd_o,
	output logic        mem_en_o,
	output strip_t      mem_wdf_data_o,
	output strip_mask_t mem_wdf_mask_o,
	output logic        mem_wdf_wren_o,
	output logic        mem_wdf_end_o
);

	seq_state_e state;
	seq_state_e next_state;
	ch_id_t op_ch;
	logic op_we;
	mem_addr_t op_addr;
	strip_t op_data;
	strip_mask_t op_mask;
	logic ack0_q;
	logic ack1_q;
	logic ack_fall;
	logic rd_strip;

	assign rd_strip = mem_rd_data_valid_i & mem_rd_data_end_i;

	// The access ends on the falling edge of the granted channel's ack
	assign ack_fall = (op_ch == 1'b0) ? (ack0_q & ~ack0_i) : (ack1_q & ~ack1_i);

	always_ff @(posedge mem_ui_clk) begin
		if (mem_ui_rst) begin
			ack0_q <= 1'b0;
			ack1_q <= 1'b0;
		end else begin
			ack0_q <= ack0_i;
			ack1_q <= ack1_i;
		end
	end

	// ========================================================================
	// State machine
	// ========================================================================
	always_comb begin
		next_state = state;
		case (state)
			IDLE:       if (grant_i) next_state = PRESET1;
			PRESET1:    next_state = PRESET2;
			PRESET2:    next_state = op_we ? SEND_DATA : SET_CMD_RD;
			SEND_DATA:  if (mem_wdf_rdy_i) next_state = SET_CMD_WR;
			SET_CMD_WR: if (mem_rdy_i) next_state = WAIT_NACK;
			SET_CMD_RD: if (mem_rdy_i) next_state = WAIT_RD;
			WAIT_RD:    if (rd_strip) next_state = WAIT_NACK;
			WAIT_NACK:  if (ack_fall) next_state = IDLE;
			default:    next_state = IDLE;
		endcase
	end

	always_ff @(posedge mem_ui_clk) begin
		if (mem_ui_rst)
			state <= IDLE;
		else
			state <= next_state;
	end

	// Operation captured at the grant
	always_ff @(posedge mem_ui_clk) begin
		if (state == IDLE && grant_i) begin
			op_ch <= grant_ch_i;
			op_we <= grant_we_i;
			op_addr <= grant_addr_i;
			op_data <= grant_data_i;
			op_mask <= grant_mask_i;
		end
	end

	// ========================================================================
	// MIG handshakes, each held until its ready is seen
	// ========================================================================
	always_ff @(posedge mem_ui_clk) begin
		if (mem_ui_rst) begin
			mem_en_o <= 1'b0;
			mem_wdf_wren_o <= 1'b0;
			mem_wdf_end_o <= 1'b0;
			mem_wdf_mask_o <= '1;
		end else begin
			case (state)
				PRESET1: begin
					if (op_we)
						mem_wdf_mask_o <= op_mask;
				end
				PRESET2: begin
					// Write data goes first, a read goes straight to the command
					if (op_we) begin
						mem_wdf_wren_o <= 1'b1;
						mem_wdf_end_o <= 1'b1;
					end else begin
						mem_en_o <= 1'b1;
					end
				end
				SEND_DATA: begin
					if (mem_wdf_rdy_i) begin
						mem_wdf_wren_o <= 1'b0;
						mem_wdf_end_o <= 1'b0;
						mem_en_o <= 1'b1;
					end
				end
				SET_CMD_WR: begin
					if (mem_rdy_i) begin
						mem_en_o <= 1'b0;
						mem_wdf_mask_o <= '1;
					end
				end
				SET_CMD_RD: begin
					if (mem_rdy_i)
						mem_en_o <= 1'b0;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge mem_ui_clk) begin
		if (state == PRESET1) begin
			mem_addr_o <= op_addr;
			mem_wdf_data_o <= op_data;
		end
		if (state == PRESET2)
			mem_cmd_o <= op_we ? CMD_WRITE : CMD_READ;
	end

	assign seq_idle_o = (state == IDLE);
	assign fill_o = (state == WAIT_RD) & rd_strip;
	assign fill_ch_o = op_ch;
	assign fill_data_o = mem_rd_data_i;
	assign wr_done_o = (state == SET_CMD_WR) & mem_rdy_i;
	assign done_ch_o = op_ch;

endmodule

// ==== verilog/mpmc_read_cache.sv ====
`timescale 1ns/1ns

module mpmc_read_cache import mpmc_pkg::*; (
	input  logic      mem_ui_clk,
	input  logic      mem_ui_rst,
	input  logic      cyc0_i,
	input  logic      stb0_i,
	input  logic      cyc1_i,
	input  logic      stb1_i,
	input  logic      q_cs0_i,
	input  logic      q_we0_i,
	input  bus_addr_t q_adr0_i,
	input  logic      q_cs1_i,
	input  logic      q_we1_i,
	input  bus_addr_t q_adr1_i,
	input  logic      grant_i,
	input  ch_id_t    grant_ch_i,
	input  logic      grant_we_i,
	input  mem_addr_t grant_addr_i,
	input  logic      fill_i,
	input  ch_id_t    fill_ch_i,
	input  strip_t    fill_data_i,
	input  logic      wr_done_i,
	input  ch_id_t    done_ch_i,
	output logic      hit0_o,
	output logic      hit1_o,
	output logic      ack0_o,
	output logic      ack1_o,
	output logic      acki0_o,
	output logic      acki1_o,
	output ch0_data_t dat0_o,
	output ch1_data_t dat1_o
);

	bus_addr_t tag [2];
	strip_t line [2];
	bus_addr_t grant_bus;
	bus_addr_t pend_adr;
	logic live0;
	logic live1;

	assign live0 = cyc0_i & stb0_i;
	assign live1 = cyc1_i & stb1_i;
	assign grant_bus = {{(BUS_AW - MEM_AW){1'b0}}, grant_addr_i};

	assign hit0_o = q_cs0_i & ~q_we0_i
		& (q_adr0_i[BUS_AW-1:STRIP_LSB] == tag[0][BUS_AW-1:STRIP_LSB]);
	assign hit1_o = q_cs1_i & ~q_we1_i
		& (q_adr1_i[BUS_AW-1:STRIP_LSB] == tag[1][BUS_AW-1:STRIP_LSB]);

	// ========================================================================
	// Tags and strip data
	// ========================================================================
	always_ff @(posedge mem_ui_clk) begin
		if (mem_ui_rst) begin
			for (int i = 0; i < 2; i++)
				tag[i] <= INVALID_TAG;
		end else begin
			// A write drops every copy of its strip
			if (grant_i && grant_we_i) begin
				for (int i = 0; i < 2; i++) begin
					if (tag[i][BUS_AW-1:STRIP_LSB] == grant_bus[BUS_AW-1:STRIP_LSB])
						tag[i] <= INVALID_TAG;
				end
			end
			// Line is being refilled
			if (grant_i && !grant_we_i)
				tag[grant_ch_i] <= INVALID_TAG;
			if (fill_i)
				tag[fill_ch_i] <= pend_adr;
		end
	end

	always_ff @(posedge mem_ui_clk) begin
		if (grant_i && !grant_we_i)
			pend_adr <= grant_bus;
		if (fill_i)
			line[fill_ch_i] <= fill_data_i;
	end

	// ========================================================================
	// Ack levels, cleared as soon as the request goes away
	// ========================================================================
	always_ff @(posedge mem_ui_clk) begin
		if (mem_ui_rst) begin
			acki0_o <= 1'b0;
			acki1_o <= 1'b0;
		end else begin
			if (hit0_o || (wr_done_i && done_ch_i == 1'b0))
				acki0_o <= 1'b1;
			if (hit1_o || (wr_done_i && done_ch_i == 1'b1))
				acki1_o <= 1'b1;
			if (!live0)
				acki0_o <= 1'b0;
			if (!live1)
				acki1_o <= 1'b0;
		end
	end

	assign ack0_o = acki0_o & live0;
	assign ack1_o = acki1_o & live1;

	// Read data, zero while deselected
	always_ff @(posedge mem_ui_clk) begin
		if (mem_ui_rst) begin
			dat0_o <= '0;
			dat1_o <= '0;
		end else begin
			dat0_o <= live0 ? line[0] : '0;
			dat1_o <= live1 ? line[1][{q_adr1_i[STRIP_LSB-1:LANE_LSB], 5'd0} +: CH1_W] : '0;
		end
	end

endmodule

// ==== verilog/mpmc_top.sv ====
`timescale 1ns/1ns

module mpmc_top import mpmc_pkg::*; (
	input  logic        mem_ui_clk,
	input  logic        mem_ui_rst,
	// Display channel
	input  logic        cyc0_i, stb0_i, we0_i,
	input  ch0_sel_t    sel0_i,
	input  bus_addr_t   adr0_i,
	input  ch0_data_t   dat0_i,
	output ch0_data_t   dat0_o,
	output logic        ack0_o,
	// CPU channel
	input  logic        cyc1_i, stb1_i, we1_i,
	input  ch1_sel_t    sel1_i,
	input  bus_addr_t   adr1_i,
	input  ch1_data_t   dat1_i,
	output ch1_data_t   dat1_o,
	output logic        ack1_o,
	// MIG user port
	output mem_addr_t   mem_addr_o,
	output mig_cmd_t    mem_cmd_o,
	output logic        mem_en_o,
	output strip_t      mem_wdf_data_o,
	output strip_mask_t mem_wdf_mask_o,
	output logic        mem_wdf_wren_o,
	output logic        mem_wdf_end_o,
	input  strip_t      mem_rd_data_i,
	input  logic        mem_rd_data_valid_i, mem_rd_data_end_i,
	input  logic        mem_rdy_i, mem_wdf_rdy_i
);

	logic q_cs0, q_we0, q_cs1, q_we1;
	bus_addr_t q_adr0, q_adr1;
	logic hit0, hit1, seq_idle, acki0, acki1;
	logic grant, grant_we, fill, wr_done;
	ch_id_t grant_ch, fill_ch, done_ch;
	mem_addr_t grant_addr;
	strip_t grant_data, fill_data;
	strip_mask_t grant_mask;

	mpmc_channel_decode u_decode (
		.mem_ui_clk(mem_ui_clk), .mem_ui_rst(mem_ui_rst),
		.cyc0_i(cyc0_i), .stb0_i(stb0_i), .we0_i(we0_i), .sel0_i(sel0_i),
		.adr0_i(adr0_i), .dat0_i(dat0_i),
		.cyc1_i(cyc1_i), .stb1_i(stb1_i), .we1_i(we1_i), .sel1_i(sel1_i),
		.adr1_i(adr1_i), .dat1_i(dat1_i),
		.hit0_i(hit0), .hit1_i(hit1), .seq_idle_i(seq_idle),
		.q_cs0_o(q_cs0), .q_we0_o(q_we0), .q_adr0_o(q_adr0),
		.q_cs1_o(q_cs1), .q_we1_o(q_we1), .q_adr1_o(q_adr1),
		.grant_o(grant), .grant_ch_o(grant_ch), .grant_we_o(grant_we),
		.grant_addr_o(grant_addr), .grant_data_o(grant_data), .grant_mask_o(grant_mask)
	);

	mpmc_mig_sequencer u_seq (
		.mem_ui_clk(mem_ui_clk), .mem_ui_rst(mem_ui_rst),
		.grant_i(grant), .grant_ch_i(grant_ch), .grant_we_i(grant_we),
		.grant_addr_i(grant_addr), .grant_data_i(grant_data), .grant_mask_i(grant_mask),
		.ack0_i(acki0), .ack1_i(acki1),
		.mem_rd_data_i(mem_rd_data_i), .mem_rd_data_valid_i(mem_rd_data_valid_i),
		.mem_rd_data_end_i(mem_rd_data_end_i), .mem_rdy_i(mem_rdy_i),
		.mem_wdf_rdy_i(mem_wdf_rdy_i),
		.seq_idle_o(seq_idle), .fill_o(fill), .fill_ch_o(fill_ch), .fill_data_o(fill_data),
		.wr_done_o(wr_done), .done_ch_o(done_ch),
		.mem_addr_o(mem_addr_o), .mem_cmd_o(mem_cmd_o), .mem_en_o(mem_en_o),
		.mem_wdf_data_o(mem_wdf_data_o), .mem_wdf_mask_o(mem_wdf_mask_o),
		.mem_wdf_wren_o(mem_wdf_wren_o), .mem_wdf_end_o(mem_wdf_end_o)
	);

	mpmc_read_cache u_cache (
		.mem_ui_clk(mem_ui_clk), .mem_ui_rst(mem_ui_rst),
		.cyc0_i(cyc0_i), .stb0_i(stb0_i), .cyc1_i(cyc1_i), .stb1_i(stb1_i),
		.q_cs0_i(q_cs0), .q_we0_i(q_we0), .q_adr0_i(q_adr0),
		.q_cs1_i(q_cs1), .q_we1_i(q_we1), .q_adr1_i(q_adr1),
		.grant_i(grant), .grant_ch_i(grant_ch), .grant_we_i(grant_we),
		.grant_addr_i(grant_addr),
		.fill_i(fill), .fill_ch_i(fill_ch), .fill_data_i(fill_data),
		.wr_done_i(wr_done), .done_ch_i(done_ch),
		.hit0_o(hit0), .hit1_o(hit1), .ack0_o(ack0_o), .ack1_o(ack1_o),
		.acki0_o(acki0), .acki1_o(acki1), .dat0_o(dat0_o), .dat1_o(dat1_o)
	);

endmodule

// ==== verification/mpmc_mig_model.sv ====
`timescale 1ns/1ns

module mpmc_mig_model import mpmc_pkg::*; (
	input  logic        mem_ui_clk,
	input  logic        mem_ui_rst,
	input  mem_addr_t   mem_addr_i,
	input  mig_cmd_t    mem_cmd_i,
	input  logic        mem_en_i,
	input  strip_t      mem_wdf_data_i,
	input  strip_mask_t mem_wdf_mask_i,
	input  logic        mem_wdf_wren_i,
	input  logic        mem_wdf_end_i,
	output strip_t      mem_rd_data_o,
	output logic        mem_rd_data_valid_o,
	output logic        mem_rd_data_end_o,
	output logic        mem_rdy_o,
	output logic        mem_wdf_rdy_o
);

	strip_t mem [256];
	strip_t wbuf;
	strip_mask_t wmask;
	logic [7:0] rd_idx;
	int rd_issued;
	int rd_served;
	int rd_wait;
	logic rd_waiting;
	int unsigned lcg_state;

	function int unsigned next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16;
	endfunction

	initial begin
		// Byte k of strip L holds L*16+k
		for (int l = 0; l < 256; l++)
			for (int k = 0; k < STRIP_BYTES; k++)
				mem[l][k*8 +: 8] = 8'(l * 16 + k);
		lcg_state = 32'd9934 ^ 32'h0000_5a5a;
		rd_issued = 0;
		rd_served = 0;
		rd_wait = 0;
		rd_waiting = 1'b0;
		mem_rd_data_o = '0;
		mem_rd_data_valid_o = 1'b0;
		mem_rd_data_end_o = 1'b0;
		mem_rdy_o = 1'b0;
		mem_wdf_rdy_o = 1'b0;
	end

	// Accepted handshakes, seen on the rising edge
	always @(posedge mem_ui_clk) begin
		if (mem_wdf_wren_i && mem_wdf_end_i && mem_wdf_rdy_o) begin
			wbuf = mem_wdf_data_i;
			wmask = mem_wdf_mask_i;
		end
		if (mem_en_i && mem_rdy_o) begin
			if (mem_cmd_i == CMD_WRITE) begin
				for (int k = 0; k < STRIP_BYTES; k++)
					if (!wmask[k])
						mem[mem_addr_i[11:4]][k*8 +: 8] = wbuf[k*8 +: 8];
			end else begin
				rd_idx = mem_addr_i[11:4];
				rd_issued++;
			end
		end
	end

	// Ready back-pressure and read return, driven on the falling edge
	always @(negedge mem_ui_clk) begin
		mem_rd_data_valid_o = 1'b0;
		mem_rd_data_end_o = 1'b0;
		if (mem_ui_rst) begin
			mem_rdy_o = 1'b0;
			mem_wdf_rdy_o = 1'b0;
		end else begin
			mem_rdy_o = (next_rand() % 4) != 0;
			mem_wdf_rdy_o = (next_rand() % 4) != 0;
			if (rd_issued != rd_served) begin
				if (!rd_waiting) begin
					rd_waiting = 1'b1;
					rd_wait = next_rand() % 8;
				end else if (rd_wait == 0) begin
					mem_rd_data_o = mem[rd_idx];
					mem_rd_data_valid_o = 1'b1;
					mem_rd_data_end_o = 1'b1;
					rd_served++;
					rd_waiting = 1'b0;
				end else begin
					rd_wait--;
				end
			end
		end
	end

endmodule

// ==== verification/mpmc_properties.sv ====
`timescale 1ns/1ns

module mpmc_properties import mpmc_pkg::*; (
	input logic        mem_ui_clk,
	input logic        mem_ui_rst,
	input seq_state_e  state_i,
	input ch_id_t      op_ch_i,
	input logic        op_we_i,
	input logic        ack0_i,
	input logic        ack1_i,
	input logic        mem_en_i,
	input mem_addr_t   mem_addr_i,
	input mig_cmd_t    mem_cmd_i,
	input logic        mem_rdy_i,
	input logic        mem_wdf_wren_i,
	input strip_t      mem_wdf_data_i,
	input logic        mem_wdf_rdy_i
);

	// Command stays put until the MIG takes it
	a_en_hold: assert property (@(posedge mem_ui_clk) disable iff (mem_ui_rst)
		mem_en_i && !mem_rdy_i |=> mem_en_i && $stable(mem_addr_i) && $stable(mem_cmd_i))
		else $error("mem_en dropped or changed before mem_rdy");

	a_wren_hold: assert property (@(posedge mem_ui_clk) disable iff (mem_ui_rst)
		mem_wdf_wren_i && !mem_wdf_rdy_i |=> mem_wdf_wren_i && $stable(mem_wdf_data_i))
		else $error("mem_wdf_wren dropped or data changed before mem_wdf_rdy");

	// A write is only acked once its command is accepted
	a_no_early_ack: assert property (@(posedge mem_ui_clk) disable iff (mem_ui_rst)
		op_we_i && (state_i inside {PRESET1, PRESET2, SEND_DATA, SET_CMD_WR})
		|-> !(op_ch_i ? ack1_i : ack0_i))
		else $error("ack raised for a write before its command was accepted");

	a_idle_quiet: assert property (@(posedge mem_ui_clk) disable iff (mem_ui_rst)
		state_i == IDLE |-> !mem_en_i && !mem_wdf_wren_i)
		else $error("MIG strobes active in IDLE");

endmodule

bind mpmc_mig_sequencer mpmc_properties u_props (
	.mem_ui_clk(mem_ui_clk), .mem_ui_rst(mem_ui_rst),
	.state_i(state), .op_ch_i(op_ch), .op_we_i(op_we),
	.ack0_i(ack0_i), .ack1_i(ack1_i),
	.mem_en_i(mem_en_o), .mem_addr_i(mem_addr_o), .mem_cmd_i(mem_cmd_o),
	.mem_rdy_i(mem_rdy_i), .mem_wdf_wren_i(mem_wdf_wren_o),
	.mem_wdf_data_i(mem_wdf_data_o), .mem_wdf_rdy_i(mem_wdf_rdy_i)
);

// ==== verification/tb_mpmc.sv ====
`timescale 1ns/1ns

module tb_mpmc import mpmc_pkg::*; ();

	localparam int TIMEOUT = 2000;

	logic mem_ui_clk;
	logic mem_ui_rst;
	logic cyc0, stb0, we0, ack0;
	ch0_sel_t sel0;
	bus_addr_t adr0;
	ch0_data_t wdat0, rdat0;
	logic cyc1, stb1, we1, ack1;
	ch1_sel_t sel1;
	bus_addr_t adr1;
	ch1_data_t wdat1, rdat1;
	mem_addr_t mem_addr;
	mig_cmd_t mem_cmd;
	logic mem_en, mem_wdf_wren, mem_wdf_end, mem_rd_valid, mem_rd_end, mem_rdy, mem_wdf_rdy;
	strip_t mem_wdf_data, mem_rd_data;
	strip_mask_t mem_wdf_mask;

	strip_t ref_mem [256];
	int unsigned lcg_state;
	int errors;
	int checks;
	int cmd_count;

	mpmc_top dut (
		.mem_ui_clk(mem_ui_clk), .mem_ui_rst(mem_ui_rst),
		.cyc0_i(cyc0), .stb0_i(stb0), .we0_i(we0), .sel0_i(sel0), .adr0_i(adr0),
		.dat0_i(wdat0), .dat0_o(rdat0), .ack0_o(ack0),
		.cyc1_i(cyc1), .stb1_i(stb1), .we1_i(we1), .sel1_i(sel1), .adr1_i(adr1),
		.dat1_i(wdat1), .dat1_o(rdat1), .ack1_o(ack1),
		.mem_addr_o(mem_addr), .mem_cmd_o(mem_cmd), .mem_en_o(mem_en),
		.mem_wdf_data_o(mem_wdf_data), .mem_wdf_mask_o(mem_wdf_mask),
		.mem_wdf_wren_o(mem_wdf_wren), .mem_wdf_end_o(mem_wdf_end),
		.mem_rd_data_i(mem_rd_data), .mem_rd_data_valid_i(mem_rd_valid),
		.mem_rd_data_end_i(mem_rd_end), .mem_rdy_i(mem_rdy), .mem_wdf_rdy_i(mem_wdf_rdy)
	);

	mpmc_mig_model u_mig (
		.mem_ui_clk(mem_ui_clk), .mem_ui_rst(mem_ui_rst),
		.mem_addr_i(mem_addr), .mem_cmd_i(mem_cmd), .mem_en_i(mem_en),
		.mem_wdf_data_i(mem_wdf_data), .mem_wdf_mask_i(mem_wdf_mask),
		.mem_wdf_wren_i(mem_wdf_wren), .mem_wdf_end_i(mem_wdf_end),
		.mem_rd_data_o(mem_rd_data), .mem_rd_data_valid_o(mem_rd_valid),
		.mem_rd_data_end_o(mem_rd_end), .mem_rdy_o(mem_rdy), .mem_wdf_rdy_o(mem_wdf_rdy)
	);

	always #10 mem_ui_clk = ~mem_ui_clk;

	// Commands accepted by the MIG
	always @(posedge mem_ui_clk)
		if (mem_en && mem_rdy)
			cmd_count++;

	function int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [127:0] rand_wide();
		return {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
	endfunction

	task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
		input string what);
		checks++;
		if (got !== exp) begin
			$display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	// ========================================================================
	// Reference memory with the fill rule of the MIG model
	// ========================================================================
	task automatic ref_write0(input bus_addr_t adr, input ch0_sel_t sel, input ch0_data_t dat);
		for (int k = 0; k < 16; k++)
			if (sel[k])
				ref_mem[adr[11:4]][k*8 +: 8] = dat[k*8 +: 8];
	endtask

	task automatic ref_write1(input bus_addr_t adr, input ch1_sel_t sel, input ch1_data_t dat);
		int lane;
		lane = adr[3:2];
		for (int j = 0; j < 4; j++)
			if (sel[j])
				ref_mem[adr[11:4]][(lane*4 + j)*8 +: 8] = dat[j*8 +: 8];
	endtask

	// ========================================================================
	// One bus cycle task per channel
	// ========================================================================
	task automatic access0(input logic we, input ch0_sel_t sel, input bus_addr_t adr,
		input ch0_data_t dat, output ch0_data_t rdata);
		int cnt;
		logic acked;
		cnt = 0;
		acked = 1'b0;
		rdata = '0;
		@(negedge mem_ui_clk);
		cyc0 = 1'b1;
		stb0 = 1'b1;
		we0 = we;
		sel0 = sel;
		adr0 = adr;
		wdat0 = dat;
		while (!acked && cnt < TIMEOUT) begin
			@(negedge mem_ui_clk);
			if (ack0) begin
				acked = 1'b1;
				rdata = rdat0;
			end
			cnt++;
		end
		cyc0 = 1'b0;
		stb0 = 1'b0;
		we0 = 1'b0;
		if (!acked) begin
			$display("Timeout at %0t ns: channel 0 got no ack for address %h", $time, adr);
			errors++;
		end
	endtask

	task automatic access1(input logic we, input ch1_sel_t sel, input bus_addr_t adr,
		input ch1_data_t dat, output ch1_data_t rdata);
		int cnt;
		logic acked;
		cnt = 0;
		acked = 1'b0;
		rdata = '0;
		@(negedge mem_ui_clk);
		cyc1 = 1'b1;
		stb1 = 1'b1;
		we1 = we;
		sel1 = sel;
		adr1 = adr;
		wdat1 = dat;
		while (!acked && cnt < TIMEOUT) begin
			@(negedge mem_ui_clk);
			if (ack1) begin
				acked = 1'b1;
				rdata = rdat1;
			end
			cnt++;
		end
		cyc1 = 1'b0;
		stb1 = 1'b0;
		we1 = 1'b0;
		if (!acked) begin
			$display("Timeout at %0t ns: channel 1 got no ack for address %h", $time, adr);
			errors++;
		end
	endtask

	// Channel 0 keeps to strips 32..39 and channel 1 to strips 64..71
	task automatic random_ch0(input int n);
		bus_addr_t adr;
		ch0_sel_t sel;
		ch0_data_t dat, rd;
		logic we;
		for (int i = 0; i < n; i++) begin
			adr = {20'd0, 8'(32 + (lcg_next() >> 16) % 8), 4'd0};
			we = (lcg_next() >> 16) % 2;
			sel = 16'(lcg_next() >> 16);
			dat = rand_wide();
			access0(we, sel, adr, dat, rd);
			if (we)
				ref_write0(adr, sel, dat);
			else
				check_value(rd, ref_mem[adr[11:4]], "random ch0 read");
		end
	endtask

	task automatic random_ch1(input int n);
		bus_addr_t adr;
		ch1_sel_t sel;
		ch1_data_t dat, rd;
		logic we;
		for (int i = 0; i < n; i++) begin
			adr = {20'd0, 8'(64 + (lcg_next() >> 16) % 8), 2'(lcg_next() >> 16), 2'd0};
			we = (lcg_next() >> 16) % 2;
			sel = 4'(lcg_next() >> 28);
			dat = lcg_next();
			access1(we, sel, adr, dat, rd);
			if (we)
				ref_write1(adr, sel, dat);
			else
				check_value(rd, ref_mem[adr[11:4]][adr[3:2]*32 +: 32], "random ch1 read");
		end
	endtask

	task automatic report_test(input int num, input string name, input int errs_before);
		$display("test %0d %s: %s", num, name, (errors == errs_before) ? "passed" : "failed");
	endtask

	initial begin
		ch0_data_t d0, r0;
		ch0_sel_t s0;
		ch1_data_t r1;
		int e0;
		int cmds;
		logic seen;
		mem_ui_clk = 1'b0;
		mem_ui_rst = 1'b1;
		{cyc0, stb0, we0, cyc1, stb1, we1} = '0;
		sel0 = '0;
		adr0 = '0;
		wdat0 = '0;
		sel1 = '0;
		adr1 = '0;
		wdat1 = '0;
		errors = 0;
		checks = 0;
		cmd_count = 0;
		lcg_state = 32'd9934;
		for (int l = 0; l < 256; l++)
			for (int k = 0; k < 16; k++)
				ref_mem[l][k*8 +: 8] = 8'(l * 16 + k);
		repeat (8) @(posedge mem_ui_clk);
		@(negedge mem_ui_clk);
		mem_ui_rst = 1'b0;

		e0 = errors;
		@(negedge mem_ui_clk);
		check_value(ack0, 0, "ack0 after reset");
		check_value(ack1, 0, "ack1 after reset");
		check_value(mem_en, 0, "mem_en after reset");
		check_value(mem_wdf_wren, 0, "mem_wdf_wren after reset");
		check_value(rdat0, 0, "dat0 after reset");
		check_value(rdat1, 0, "dat1 after reset");
		report_test(1, "reset state", e0);

		e0 = errors;
		s0 = 16'(lcg_next());
		d0 = rand_wide();
		access0(1'b1, s0, 32'h0000_0050, d0, r0);
		ref_write0(32'h0000_0050, s0, d0);
		access0(1'b0, '0, 32'h0000_0050, '0, r0);
		check_value(r0, ref_mem[5], "ch0 read after write");
		report_test(2, "ch0 write and read back", e0);

		e0 = errors;
		access0(1'b0, '0, 32'h0000_0070, '0, r0);
		check_value(r0, ref_mem[7], "ch0 read before ch1 write");
		access1(1'b1, 4'b1011, 32'h0000_0078, 32'hA5C3_1E77, r1);
		ref_write1(32'h0000_0078, 4'b1011, 32'hA5C3_1E77);
		access0(1'b0, '0, 32'h0000_0070, '0, r0);
		check_value(r0, ref_mem[7], "ch0 re-read after ch1 write");
		report_test(3, "ch1 narrow write and invalidation", e0);

		e0 = errors;
		access1(1'b0, '0, 32'h0000_0094, '0, r1);
		check_value(r1, ref_mem[9][63:32], "ch1 first read");
		cmds = cmd_count;
		access1(1'b0, '0, 32'h0000_009C, '0, r1);
		check_value(r1, ref_mem[9][127:96], "ch1 cached read");
		// A wrongly granted hit would raise mem_en only after the ack
		seen = 1'b0;
		for (int i = 0; i < 16; i++) begin
			@(negedge mem_ui_clk);
			seen = seen | mem_en;
		end
		check_value(seen, 0, "mem_en during cached read");
		check_value(cmd_count, cmds, "MIG commands during cached read");
		report_test(4, "ch1 read hit", e0);

		// Out-of-window request must be ignored
		e0 = errors;
		cmds = cmd_count;
		seen = 1'b0;
		@(negedge mem_ui_clk);
		cyc0 = 1'b1;
		stb0 = 1'b1;
		adr0 = 32'h2000_0040;
		for (int i = 0; i < 50; i++) begin
			@(negedge mem_ui_clk);
			seen = seen | ack0;
		end
		cyc0 = 1'b0;
		stb0 = 1'b0;
		check_value(seen, 0, "ack for out-of-window request");
		check_value(cmd_count, cmds, "MIG commands for out-of-window request");
		report_test(5, "address window", e0);

		e0 = errors;
		fork
			random_ch0(100);
			random_ch1(100);
		join
		report_test(6, "random traffic on both channels", e0);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// ==== filelist.f ====
verilog/mpmc_pkg.sv
verilog/mpmc_channel_decode.sv
verilog/mpmc_mig_sequencer.sv
verilog/mpmc_read_cache.sv
verilog/mpmc_top.sv
verification/mpmc_mig_model.sv
verification/mpmc_properties.sv
verification/tb_mpmc.sv
